/* include/mastermind_consts.svh */
`ifndef MASTERMIND_CONSTS_SVH
`define MASTERMIND_CONSTS_SVH

// pegs per code or guess
`define MM_PEGS 4

// bits per peg colour
`define MM_COLOR_W 3

// red or white count, 0 to 4
`define MM_SCORE_W 3

// one seven-segment digit
`define MM_SEG_W 7

`endif

/* verilog/mastermind_pkg.sv */
`default_nettype none

`include "mastermind_consts.svh"

package mastermind_pkg;

    typedef logic [`MM_COLOR_W-1:0] color_t;

    // index 0 is the first peg entered
    typedef color_t [`MM_PEGS-1:0] pegs_t;

    typedef logic [`MM_SCORE_W-1:0] score_t;

    // active low, segment g in the top bit
    typedef logic [`MM_SEG_W-1:0] seg_t;

    typedef enum logic [2:0] {
        CODE_PEG,
        CODE_WAIT,
        GUESS_PEG,
        GUESS_WAIT,
        ROUND_HOLD
    } entry_state_e;

    typedef enum logic [1:0] {
        SCORE_IDLE,
        SCORE_RUN,
        SCORE_DONE
    } scorer_state_e;

endpackage

`default_nettype wire

/* verilog/round_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one code/guess pair handed from entry to scoring
interface round_if;
    import mastermind_pkg::*;

    logic  valid;
    logic  ready;
    pegs_t code;
    pegs_t guess;

    modport producer (
        output valid,
        output code,
        output guess,
        input  ready
    );

    modport consumer (
        input  valid,
        input  code,
        input  guess,
        output ready
    );

endinterface

`default_nettype wire

/* verilog/peg_entry.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mastermind_consts.svh"

module peg_entry (
    input  wire logic              clk,
    input  wire logic              resetn,
    input  mastermind_pkg::color_t peg_i,
    input  wire logic              load_i,
    round_if.producer              round
);
    import mastermind_pkg::*;

    entry_state_e state_q;
    logic [1:0]   idx_q;
    pegs_t        code_q;
    pegs_t        guess_q;
    logic         last_peg;

    assign last_peg = (idx_q == 2'(`MM_PEGS - 1));

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= CODE_PEG;
            idx_q   <= '0;
            code_q  <= '0;
            guess_q <= '0;
        end else begin
            case (state_q)
                // peg sampled on the first high cycle only
                CODE_PEG: begin
                    if (load_i) begin
                        code_q[idx_q] <= peg_i;
                        state_q       <= CODE_WAIT;
                    end
                end
                CODE_WAIT: begin
                    if (!load_i) begin
                        idx_q   <= idx_q + 2'd1;
                        state_q <= last_peg ? GUESS_PEG : CODE_PEG;
                    end
                end
                GUESS_PEG: begin
                    if (load_i) begin
                        guess_q[idx_q] <= peg_i;
                        state_q        <= GUESS_WAIT;
                    end
                end
                GUESS_WAIT: begin
                    if (!load_i) begin
                        idx_q   <= idx_q + 2'd1;
                        state_q <= last_peg ? ROUND_HOLD : GUESS_PEG;
                    end
                end
                // keys ignored until the scorer takes the round
                ROUND_HOLD: begin
                    if (round.ready) begin
                        state_q <= GUESS_PEG;
                    end
                end
                default: begin
                    state_q <= CODE_PEG;
                end
            endcase
        end
    end

    assign round.valid = (state_q == ROUND_HOLD);
    assign round.code  = code_q;
    assign round.guess = guess_q;

    // round must hold while the scorer is busy
    hold_while_stalled: assert property (
        @(posedge clk) disable iff (!resetn)
        round.valid && !round.ready |=>
            round.valid && $stable(round.code) && $stable(round.guess)
    );

endmodule

`default_nettype wire

/* verilog/peg_scorer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mastermind_consts.svh"

module peg_scorer (
    input  wire logic              clk,
    input  wire logic              resetn,
    round_if.consumer              round,
    output logic                   score_valid_o,
    output mastermind_pkg::score_t red_o,
    output mastermind_pkg::score_t white_o,
    output mastermind_pkg::pegs_t  guess_o
);
    import mastermind_pkg::*;

    scorer_state_e      state_q;
    logic [1:0]         pos_q;
    pegs_t              code_q;
    pegs_t              guess_q;
    logic [`MM_PEGS-1:0] claimed_q;
    score_t             red_q;
    score_t             white_q;

    color_t             cur_color;
    logic               exact;
    logic               hit;
    logic [1:0]         hit_idx;

    // lowest unclaimed guess peg with the current code colour
    always_comb begin
        cur_color = code_q[pos_q];
        exact     = (guess_q[pos_q] == cur_color);
        hit       = 1'b0;
        hit_idx   = '0;
        for (int j = `MM_PEGS - 1; j >= 0; j--) begin
            if (!claimed_q[j] && (guess_q[j] == cur_color)) begin
                hit     = 1'b1;
                hit_idx = 2'(j);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= SCORE_IDLE;
        end else begin
            case (state_q)
                SCORE_IDLE: begin
                    if (round.valid) begin
                        state_q <= SCORE_RUN;
                    end
                end
                SCORE_RUN: begin
                    if (pos_q == 2'(`MM_PEGS - 1)) begin
                        state_q <= SCORE_DONE;
                    end
                end
                default: begin
                    state_q <= SCORE_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == SCORE_IDLE) && round.valid) begin
            code_q  <= round.code;
            guess_q <= round.guess;
            pos_q   <= '0;
            red_q   <= '0;
            white_q <= '0;
            // exact matches are never available for white
            for (int j = 0; j < `MM_PEGS; j++) begin
                claimed_q[j] <= (round.code[j] == round.guess[j]);
            end
        end else if (state_q == SCORE_RUN) begin
            pos_q <= pos_q + 2'd1;
            if (exact) begin
                red_q <= red_q + 3'd1;
            end else if (hit) begin
                claimed_q[hit_idx] <= 1'b1;
                white_q            <= white_q + 3'd1;
            end
        end
    end

    assign round.ready   = (state_q == SCORE_IDLE);
    assign score_valid_o = (state_q == SCORE_DONE);
    assign red_o         = red_q;
    assign white_o       = white_q;
    assign guess_o       = guess_q;

    score_in_range: assert property (
        @(posedge clk) disable iff (!resetn)
        (state_q == SCORE_DONE) |-> (red_q + white_q <= `MM_PEGS)
    );

endmodule

`default_nettype wire

/* verilog/score_display.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mastermind_consts.svh"

module score_display (
    input  wire logic              clk,
    input  wire logic              resetn,
    input  wire logic              score_valid_i,
    input  mastermind_pkg::score_t red_i,
    input  mastermind_pkg::score_t white_i,
    input  mastermind_pkg::pegs_t  guess_i,
    output logic                   score_valid_o,
    output mastermind_pkg::score_t red_o,
    output mastermind_pkg::score_t white_o,
    output mastermind_pkg::seg_t   hex0_o,
    output mastermind_pkg::seg_t   hex1_o,
    output mastermind_pkg::seg_t   hex2_o,
    output mastermind_pkg::seg_t   hex3_o,
    output mastermind_pkg::seg_t   hex4_o,
    output mastermind_pkg::seg_t   hex5_o
);
    import mastermind_pkg::*;

    logic   valid_q;
    score_t red_q;
    score_t white_q;
    pegs_t  guess_q;

    // digits 0 to 7 only, counts and colours both fit
    function automatic seg_t digit_seg(input logic [2:0] d);
        case (d)
            3'd0:    digit_seg = 7'b100_0000;
            3'd1:    digit_seg = 7'b111_1001;
            3'd2:    digit_seg = 7'b010_0100;
            3'd3:    digit_seg = 7'b011_0000;
            3'd4:    digit_seg = 7'b001_1001;
            3'd5:    digit_seg = 7'b001_0010;
            3'd6:    digit_seg = 7'b000_0010;
            default: digit_seg = 7'b111_1000;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= 1'b0;
            red_q   <= '0;
            white_q <= '0;
            guess_q <= '0;
        end else begin
            valid_q <= score_valid_i;
            if (score_valid_i) begin
                red_q   <= red_i;
                white_q <= white_i;
                guess_q <= guess_i;
            end
        end
    end

    assign score_valid_o = valid_q;
    assign red_o         = red_q;
    assign white_o       = white_q;

    assign hex0_o = digit_seg(guess_q[0]);
    assign hex1_o = digit_seg(guess_q[1]);
    assign hex2_o = digit_seg(guess_q[2]);
    assign hex3_o = digit_seg(guess_q[3]);
    assign hex4_o = digit_seg(red_q);
    assign hex5_o = digit_seg(white_q);

    red_in_range: assert property (
        @(posedge clk) disable iff (!resetn)
        red_q <= `MM_PEGS
    );

endmodule

`default_nettype wire

/* verilog/mastermind_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mastermind_top (
    input  wire logic              clk,
    input  wire logic              resetn,
    input  mastermind_pkg::color_t peg_i,
    input  wire logic              load_i,
    output logic                   score_valid_o,
    output mastermind_pkg::score_t red_o,
    output mastermind_pkg::score_t white_o,
    output mastermind_pkg::seg_t   hex0_o,
    output mastermind_pkg::seg_t   hex1_o,
    output mastermind_pkg::seg_t   hex2_o,
    output mastermind_pkg::seg_t   hex3_o,
    output mastermind_pkg::seg_t   hex4_o,
    output mastermind_pkg::seg_t   hex5_o
);
    import mastermind_pkg::*;

    logic   score_valid;
    score_t red;
    score_t white;
    pegs_t  guess;

    round_if round_link ();

    peg_entry peg_entry_inst (
        .clk    (clk),
        .resetn (resetn),
        .peg_i  (peg_i),
        .load_i (load_i),
        .round  (round_link.producer)
    );

    peg_scorer peg_scorer_inst (
        .clk           (clk),
        .resetn        (resetn),
        .round         (round_link.consumer),
        .score_valid_o (score_valid),
        .red_o         (red),
        .white_o       (white),
        .guess_o       (guess)
    );

    score_display score_display_inst (
        .clk           (clk),
        .resetn        (resetn),
        .score_valid_i (score_valid),
        .red_i         (red),
        .white_i       (white),
        .guess_i       (guess),
        .score_valid_o (score_valid_o),
        .red_o         (red_o),
        .white_o       (white_o),
        .hex0_o        (hex0_o),
        .hex1_o        (hex1_o),
        .hex2_o        (hex2_o),
        .hex3_o        (hex3_o),
        .hex4_o        (hex4_o),
        .hex5_o        (hex5_o)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

// 4 ns clock, reset low for three rising edges at start and on restart
module tb_clock_gen (
    input  wire logic restart_i,
    output logic      clk_o,
    output logic      resetn_o
);
    logic [1:0] cnt_q = 2'd3;

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // restart edge itself counts as the first reset cycle
    always @(posedge clk_o) begin
        if (restart_i) begin
            cnt_q <= 2'd2;
        end else if (cnt_q != 2'd0) begin
            cnt_q <= cnt_q - 2'd1;
        end
    end

    assign resetn_o = (cnt_q == 2'd0) && !restart_i;

endmodule

`default_nettype wire

/* testbench/mastermind_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mastermind_consts.svh"

module mastermind_tb;
    import mastermind_pkg::*;

    localparam int GAMES       = 20;
    localparam int GUESSES     = 6;
    localparam int WATCHDOG_NS = GAMES * GUESSES * 5 * 8 * 4 + 4000;

    logic   clk;
    logic   resetn;
    logic   restart;
    color_t peg_i;
    logic   load_i;
    logic   score_valid_o;
    score_t red_o;
    score_t white_o;
    seg_t   hex0_o;
    seg_t   hex1_o;
    seg_t   hex2_o;
    seg_t   hex3_o;
    seg_t   hex4_o;
    seg_t   hex5_o;

    int     errors;
    int     checks;
    int     pulses;
    score_t exp_red[$];
    score_t exp_white[$];
    pegs_t  exp_guess[$];

    tb_clock_gen clock_gen_inst (
        .restart_i (restart),
        .clk_o     (clk),
        .resetn_o  (resetn)
    );

    mastermind_top mastermind_top_inst (
        .clk           (clk),
        .resetn        (resetn),
        .peg_i         (peg_i),
        .load_i        (load_i),
        .score_valid_o (score_valid_o),
        .red_o         (red_o),
        .white_o       (white_o),
        .hex0_o        (hex0_o),
        .hex1_o        (hex1_o),
        .hex2_o        (hex2_o),
        .hex3_o        (hex3_o),
        .hex4_o        (hex4_o),
        .hex5_o        (hex5_o)
    );

    // active-low gfedcba patterns for digits 0 to 7
    function automatic seg_t seg_for_digit(input int d);
        case (d)
            0:       return 7'b1000000;
            1:       return 7'b1111001;
            2:       return 7'b0100100;
            3:       return 7'b0110000;
            4:       return 7'b0011001;
            5:       return 7'b0010010;
            6:       return 7'b0000010;
            default: return 7'b1111000;
        endcase
    endfunction

    // white is the common colour count minus red
    function automatic void model_score(input pegs_t code, input pegs_t guess,
                                        output score_t red, output score_t white);
        int code_cnt [8];
        int guess_cnt [8];
        int r;
        int common;
        r = 0;
        common = 0;
        for (int c = 0; c < 8; c++) begin
            code_cnt[c] = 0;
            guess_cnt[c] = 0;
        end
        for (int i = 0; i < `MM_PEGS; i++) begin
            if (code[i] == guess[i]) begin
                r++;
            end
            code_cnt[code[i]]++;
            guess_cnt[guess[i]]++;
        end
        for (int c = 0; c < 8; c++) begin
            common += (code_cnt[c] < guess_cnt[c]) ? code_cnt[c] : guess_cnt[c];
        end
        red = score_t'(r);
        white = score_t'(common - r);
    endfunction

    task automatic check_score(input score_t got, input score_t exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_seg(input seg_t got, input seg_t exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_reset_state();
        check_score(red_o, 3'd0, "red after reset");
        check_score(white_o, 3'd0, "white after reset");
        check_seg(hex0_o, seg_for_digit(0), "hex0 after reset");
        check_seg(hex1_o, seg_for_digit(0), "hex1 after reset");
        check_seg(hex2_o, seg_for_digit(0), "hex2 after reset");
        check_seg(hex3_o, seg_for_digit(0), "hex3 after reset");
        check_seg(hex4_o, seg_for_digit(0), "hex4 after reset");
        check_seg(hex5_o, seg_for_digit(0), "hex5 after reset");
    endtask

    // value shows only on the first high cycle and peg_i is scrambled after
    task automatic press_peg(input color_t value);
        int high_cycles;
        int low_cycles;
        high_cycles = 1 + ($urandom % 4);
        low_cycles = 1 + ($urandom % 3);
        peg_i = value;
        load_i = 1'b1;
        for (int k = 1; k < high_cycles; k++) begin
            @(posedge clk);
            #1;
            peg_i = color_t'($urandom);
        end
        @(posedge clk);
        #1;
        load_i = 1'b0;
        peg_i = color_t'($urandom);
        repeat (low_cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_game(input int game);
        pegs_t  code;
        pegs_t  guess;
        score_t red;
        score_t white;
        int     errors_before;
        int     waited;
        errors_before = errors;
        @(posedge clk);
        #1;
        restart = 1'b1;
        @(posedge clk);
        #1;
        restart = 1'b0;
        while (!resetn) begin
            @(posedge clk);
            #1;
        end
        check_reset_state();
        pulses = 0;
        exp_red.delete();
        exp_white.delete();
        exp_guess.delete();
        for (int i = 0; i < `MM_PEGS; i++) begin
            code[i] = color_t'($urandom);
            press_peg(code[i]);
        end
        for (int n = 0; n < GUESSES; n++) begin
            // last guess repeats the code
            for (int i = 0; i < `MM_PEGS; i++) begin
                guess[i] = (n == GUESSES - 1) ? code[i] : color_t'($urandom);
            end
            model_score(code, guess, red, white);
            exp_red.push_back(red);
            exp_white.push_back(white);
            exp_guess.push_back(guess);
            for (int i = 0; i < `MM_PEGS; i++) begin
                press_peg(guess[i]);
            end
            // entry ignores keys while the round is handed over
            repeat (2) begin
                @(posedge clk);
                #1;
            end
        end
        waited = 0;
        while ((pulses < GUESSES) && (waited < 16)) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (pulses != GUESSES) begin
            $display("game %0d saw %0d score pulses for %0d guesses", game, pulses, GUESSES);
            errors++;
        end
        $display("game %0d: code %h, %0d guesses scored, %0s", game, code, pulses,
                 (errors == errors_before) ? "ok" : "with errors");
    endtask

    always @(negedge clk) begin : score_checker
        pegs_t  g;
        score_t r;
        score_t w;
        if (resetn && score_valid_o) begin
            pulses++;
            if (exp_red.size() == 0) begin
                $display("score pulse at %0t ns with no guess entered", $time);
                errors++;
            end else begin
                g = exp_guess.pop_front();
                r = exp_red.pop_front();
                w = exp_white.pop_front();
                check_score(red_o, r, "red");
                check_score(white_o, w, "white");
                check_seg(hex0_o, seg_for_digit(int'(g[0])), "hex0");
                check_seg(hex1_o, seg_for_digit(int'(g[1])), "hex1");
                check_seg(hex2_o, seg_for_digit(int'(g[2])), "hex2");
                check_seg(hex3_o, seg_for_digit(int'(g[3])), "hex3");
                check_seg(hex4_o, seg_for_digit(int'(r)), "hex4");
                check_seg(hex5_o, seg_for_digit(int'(w)), "hex5");
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("run did not finish within %0d ns", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

    initial begin
        void'($urandom(53543));
        restart = 1'b0;
        peg_i = '0;
        load_i = 1'b0;
        errors = 0;
        checks = 0;
        pulses = 0;
        for (int g = 0; g < GAMES; g++) begin
            run_game(g);
        end
        $display("games %0d, checks %0d, errors %0d", GAMES, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
verilog/mastermind_pkg.sv
verilog/round_if.sv
verilog/peg_entry.sv
verilog/peg_scorer.sv
verilog/score_display.sv
verilog/mastermind_top.sv
testbench/tb_clock_gen.sv
testbench/mastermind_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the Mastermind testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f vlog.f \
    --top-module mastermind_tb \
    -o mastermind_sim

./obj_dir/mastermind_sim | tee sim.log

if grep -q "^Everything OK$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
